/* hdl/ahb_bus.sv */
/*
 * AHB-Lite interconnect, single master
 *  - fans the master request out to every slave with bus hready
 *  - address decoder drives the slave selects
 *  - response mux and default slave return the data phase
 */

`timescale 1ns/1ns

module ahb_bus
	import ahb_pkg::*;
(
	input  logic         hclk,
	input  logic         rst_n,
	// master side
	input  mas_send_type master_in,
	output slv_send_type master_out,
	// slave side
	output mas_send_type slave_inst_out,
	output mas_send_type slave_data_out,
	output logic         hsel_slave_inst,
	output logic         hsel_slave_data,
	input  slv_send_type slave_inst_in,
	input  slv_send_type slave_data_in
);

	slv_sel_t     sel;
	mas_send_type fwd_req;
	slv_send_type dflt_rsp;

	// ==================================================
	// request fan-out
	// ==================================================
	// every slave sees the muxed hreadyout as hready
	// the master's own hready field is dropped
	always_comb begin
		fwd_req        = master_in;
		fwd_req.hready = master_out.hreadyout;
	end

	assign slave_inst_out = fwd_req;
	assign slave_data_out = fwd_req;

	// ==================================================
	// decode
	// ==================================================
	ahb_decoder u_decoder (
		.haddr (master_in.haddr),
		.sel   (sel)
	);

	assign hsel_slave_inst = sel.inst;
	assign hsel_slave_data = sel.data;

	// unmapped space
	ahb_default_slave u_default_slave (
		.hclk  (hclk),
		.rst_n (rst_n),
		.hsel  (sel.dflt),
		.req   (fwd_req),
		.rsp   (dflt_rsp)
	);

	// ==================================================
	// response path
	// ==================================================
	ahb_resp_mux u_resp_mux (
		.hclk     (hclk),
		.rst_n    (rst_n),
		.sel      (sel),
		.hready   (master_out.hreadyout),
		.rsp_inst (slave_inst_in),
		.rsp_data (slave_data_in),
		.rsp_dflt (dflt_rsp),
		.rsp      (master_out)
	);

endmodule : ahb_bus

/* hdl/ahb_decoder.sv */
/*
 * AHB-Lite address decoder
 *  - region compare of haddr against the memory map
 *  - one-hot select, default slave owns every unmapped address
 */

`timescale 1ns/1ns

module ahb_decoder
	import ahb_pkg::*;
(
	input  ahb_addr_t haddr,
	output slv_sel_t  sel
);

	// region hits
	logic hit_inst;
	logic hit_data;

	// ==================================================
	// region compare
	// ==================================================
	// only the bits above the 4 KiB offset take part
	assign hit_inst = ((haddr & REGION_MASK) == INST_BASE);
	assign hit_data = ((haddr & REGION_MASK) == DATA_BASE);

	// ==================================================
	// select generation
	// ==================================================
	// transfer qualification is left to the slaves
	// decoder looks at the address only
	always_comb begin
		sel      = '0;
		sel.inst = hit_inst;
		sel.data = hit_data;
		// nothing matched, so the default slave answers
		sel.dflt = ~(hit_inst | hit_data);
	end

endmodule : ahb_decoder

/* hdl/ahb_default_slave.sv */
/*
 * AHB-Lite default slave
 *  - accepts non-idle transfers to unmapped space
 *  - two-cycle ERROR response, hrdata held at zero
 *  - IDLE and BUSY transfers get a zero-wait OKAY
 */

`timescale 1ns/1ns

module ahb_default_slave
	import ahb_pkg::*;
(
	input  logic         hclk,
	input  logic         rst_n,
	input  logic         hsel,
	input  mas_send_type req,
	output slv_send_type rsp
);

	// error sequence states
	typedef enum logic [1:0] {
		DS_IDLE,
		DS_ERR1,
		DS_ERR2
	} ds_state_t;

	ds_state_t state_q;
	ds_state_t state_d;
	logic      accept;

	// ==================================================
	// transfer qualification
	// ==================================================
	// real transfer only, pipeline must be advancing
	assign accept = hsel & req.hready &
	                ((req.htrans == NONSEQ) | (req.htrans == SEQ));

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		state_d = state_q;
		case (state_q)
			DS_IDLE: begin
				if (accept) begin
					state_d = DS_ERR1;
				end
			end
			// first cycle holds the bus
			DS_ERR1: begin
				state_d = DS_ERR2;
			end
			// hready is high here, a new unmapped access can follow
			DS_ERR2: begin
				state_d = accept ? DS_ERR1 : DS_IDLE;
			end
			default: begin
				state_d = DS_IDLE;
			end
		endcase
	end

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			state_q <= DS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ==================================================
	// response
	// ==================================================
	// decoded straight from the state register
	always_comb begin
		rsp.hrdata    = '0;
		rsp.hresp     = (state_q == DS_ERR1) | (state_q == DS_ERR2);
		rsp.hreadyout = (state_q != DS_ERR1);
	end

endmodule : ahb_default_slave

/* hdl/ahb_pkg.sv */
/*
 * AHB-Lite bus package
 *  - address and data word types
 *  - transfer-type encoding
 *  - master request and slave response structs
 *  - one-hot slave select struct
 *  - address map of the two memory regions
 */

package ahb_pkg;

	// ==================================================
	// basic bus types
	// ==================================================
	typedef logic [31:0] ahb_addr_t;
	typedef logic [31:0] ahb_data_t;

	// htrans encoding from the AMBA spec
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// ==================================================
	// bundled bus signals
	// ==================================================
	// master request, 78 bits
	typedef struct packed {
		ahb_addr_t  haddr;
		ahb_data_t  hwdata;
		htrans_t    htrans;
		logic       hwrite;
		logic [2:0] hsize;
		logic [2:0] hburst;
		logic [3:0] hprot;
		logic       hready;
	} mas_send_type;

	// slave response, 34 bits
	// hresp 0 = OKAY, 1 = ERROR
	typedef struct packed {
		logic      hreadyout;
		ahb_data_t hrdata;
		logic      hresp;
	} slv_send_type;

	// one-hot slave select
	typedef struct packed {
		logic inst;
		logic data;
		logic dflt;
	} slv_sel_t;

	// ==================================================
	// address map, 4 KiB per region
	// ==================================================
	localparam ahb_addr_t INST_BASE   = 32'h0000_0000;
	localparam ahb_addr_t DATA_BASE   = 32'h2000_0000;
	localparam ahb_addr_t REGION_MASK = 32'hFFFF_F000;

endpackage : ahb_pkg

/* hdl/ahb_resp_mux.sv */
/*
 * AHB-Lite response multiplexer
 *  - data-phase owner register, loaded when hready is high
 *  - steers the owning slave's response back to the master
 */

`timescale 1ns/1ns

module ahb_resp_mux
	import ahb_pkg::*;
(
	input  logic         hclk,
	input  logic         rst_n,
	input  slv_sel_t     sel,
	input  logic         hready,
	input  slv_send_type rsp_inst,
	input  slv_send_type rsp_data,
	input  slv_send_type rsp_dflt,
	output slv_send_type rsp
);

	// slave that owns the current data phase
	slv_sel_t owner_q;

	// ==================================================
	// owner register
	// ==================================================
	// hready high marks the boundary between data phases
	// out of reset the default slave owns the bus, idle and ready
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			owner_q <= '{inst: 1'b0, data: 1'b0, dflt: 1'b1};
		end else if (hready) begin
			owner_q <= sel;
		end
	end

	// ==================================================
	// response steering
	// ==================================================
	always_comb begin
		if (owner_q.inst) begin
			rsp = rsp_inst;
		end else if (owner_q.data) begin
			rsp = rsp_data;
		end else begin
			// dflt, and anything not one-hot
			rsp = rsp_dflt;
		end
	end

endmodule : ahb_resp_mux

/* hdl/ahb_sram_slave.sv */
/*
 * AHB-Lite memory slave
 *  - word-wide array of MEM_WORDS entries
 *  - WAIT_STATES cycles of hreadyout low per transfer
 *  - write data sampled and read data driven in the completing cycle
 *  - word transfers only, hsize/hburst/hprot ignored
 */

`timescale 1ns/1ns

module ahb_sram_slave
	import ahb_pkg::*;
#(
	parameter int MEM_WORDS   = 1024,
	parameter int WAIT_STATES = 0
) (
	input  logic         hclk,
	input  logic         rst_n,
	input  logic         hsel,
	input  mas_send_type req,
	output slv_send_type rsp
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	// counter needs at least one bit even with zero wait states
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	ahb_data_t        mem [MEM_WORDS];

	// data-phase context
	logic             active_q;
	logic             write_q;
	ahb_addr_t        addr_q;
	logic [CNT_W-1:0] wait_cnt_q;

	logic             accept;
	logic             done;
	logic [IDX_W-1:0] idx;

	// ==================================================
	// address phase
	// ==================================================
	assign accept = hsel & req.hready &
	                ((req.htrans == NONSEQ) | (req.htrans == SEQ));

	// validity and wait counter
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			active_q   <= 1'b0;
			wait_cnt_q <= '0;
		end else if (req.hready) begin
			// previous data phase ends, next one starts
			active_q   <= accept;
			wait_cnt_q <= '0;
		end else if (active_q) begin
			// stalled by this slave, keep counting
			wait_cnt_q <= wait_cnt_q + 1'b1;
		end
	end

	// latched address and direction
	always_ff @(posedge hclk) begin
		if (accept) begin
			addr_q  <= req.haddr;
			write_q <= req.hwrite;
		end
	end

	// ==================================================
	// data phase
	// ==================================================
	// last cycle once all wait states have passed
	assign done = active_q & (wait_cnt_q == CNT_W'(WAIT_STATES));

	// word index from the address above the byte lanes
	assign idx = addr_q[IDX_W+1:2];

	// write on completion, hwdata valid in that cycle
	always_ff @(posedge hclk) begin
		if (done && write_q) begin
			mem[idx] <= req.hwdata;
		end
	end

	// ready when idle or completing, never an error
	always_comb begin
		rsp.hreadyout = ~active_q | done;
		rsp.hresp     = 1'b0;
		rsp.hrdata    = (done && !write_q) ? mem[idx] : '0;
	end

endmodule : ahb_sram_slave

/* hdl/ahb_subsys_top.sv */
/*
 * AHB-Lite subsystem top
 *  - interconnect for one master
 *  - zero-wait instruction memory
 *  - data memory with configurable wait states
 */

`timescale 1ns/1ns

module ahb_subsys_top
	import ahb_pkg::*;
#(
	parameter int MEM_WORDS        = 1024,
	parameter int INST_WAIT_STATES = 0,
	parameter int DATA_WAIT_STATES = 2
) (
	input  logic         hclk,
	input  logic         rst_n,
	input  mas_send_type master_in,
	output slv_send_type master_out
);

	// bus to memory wiring
	mas_send_type inst_req;
	mas_send_type data_req;
	logic         hsel_inst;
	logic         hsel_data;
	slv_send_type inst_rsp;
	slv_send_type data_rsp;

	// ==================================================
	// interconnect
	// ==================================================
	ahb_bus u_bus (
		.hclk            (hclk),
		.rst_n           (rst_n),
		.master_in       (master_in),
		.master_out      (master_out),
		.slave_inst_out  (inst_req),
		.slave_data_out  (data_req),
		.hsel_slave_inst (hsel_inst),
		.hsel_slave_data (hsel_data),
		.slave_inst_in   (inst_rsp),
		.slave_data_in   (data_rsp)
	);

	// ==================================================
	// memories
	// ==================================================
	ahb_sram_slave #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (INST_WAIT_STATES)
	) u_inst_mem (
		.hclk  (hclk),
		.rst_n (rst_n),
		.hsel  (hsel_inst),
		.req   (inst_req),
		.rsp   (inst_rsp)
	);

	ahb_sram_slave #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (DATA_WAIT_STATES)
	) u_data_mem (
		.hclk  (hclk),
		.rst_n (rst_n),
		.hsel  (hsel_data),
		.req   (data_req),
		.rsp   (data_rsp)
	);

endmodule : ahb_subsys_top

/* project.f */
hdl/ahb_pkg.sv
hdl/ahb_decoder.sv
hdl/ahb_default_slave.sv
hdl/ahb_resp_mux.sv
hdl/ahb_sram_slave.sv
hdl/ahb_bus.sv
hdl/ahb_subsys_top.sv
tests/ahb_bus_asserts.sv
tests/ahb_bus_tb.sv

/* run.sh */
#!/bin/sh
# build and run the AHB-Lite subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module ahb_bus_tb -o sim_ahb_bus

if ! ./obj_dir/sim_ahb_bus > sim.log 2>&1; then
	echo "simulation exited with a non-zero status"
fi
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

/* tests/ahb_bus_asserts.sv */
/*
 * protocol assertions for the AHB-Lite interconnect
 *  - two-cycle ERROR response shape
 *  - one-hot slave select
 *  - bus ready in the first cycle after reset
 */

`timescale 1ns/1ns

module ahb_bus_asserts
	import ahb_pkg::*;
(
	input logic         hclk,
	input logic         rst_n,
	input slv_sel_t     sel,
	input slv_send_type master_out
);

	// ==================================================
	// response shape
	// ==================================================
	// first error cycle stalls, second one releases the bus
	err_two_cycle: assert property (
		@(posedge hclk) disable iff (!rst_n)
		(master_out.hresp && !master_out.hreadyout) |=>
			(master_out.hresp && master_out.hreadyout)
	) else $error("ERROR with hreadyout low not followed by ERROR with hreadyout high");

	// decoder gives every address exactly one owner
	sel_onehot: assert property (
		@(posedge hclk) disable iff (!rst_n)
		$onehot({sel.inst, sel.data, sel.dflt})
	) else $error("slave select is not one-hot");

	ready_after_reset: assert property (
		@(posedge hclk) $rose(rst_n) |-> master_out.hreadyout
	) else $error("hreadyout low in the first cycle after reset");

endmodule : ahb_bus_asserts

bind ahb_bus ahb_bus_asserts u_asserts (
	.hclk       (hclk),
	.rst_n      (rst_n),
	.sel        (sel),
	.master_out (master_out)
);

/* tests/ahb_bus_tb.sv */
/*
 * testbench for the AHB-Lite subsystem
 *  - directed table of transfers applied by a pipelined master
 *  - xorshift random traffic against a reference memory model
 *  - response, wait-state and read-data checks per data phase
 */

`timescale 1ns/1ns

module ahb_bus_tb
	import ahb_pkg::*;
();

	localparam int MEM_WORDS = 1024;
	localparam int INST_WS   = 0;
	localparam int DATA_WS   = 2;
	localparam int WINDOW    = 32;
	localparam int MAX_WAIT  = 16;
	localparam int N_RANDOM  = 240;

	// one transfer and its expected data phase
	typedef struct packed {
		htrans_t   htrans;
		logic      hwrite;
		ahb_addr_t haddr;
		ahb_data_t hwdata;
		logic      exp_resp;
		ahb_data_t exp_rdata;
	} xfer_t;

	logic         hclk;
	logic         rst_n;
	mas_send_type master_in;
	slv_send_type master_out;

	xfer_t        table_rows [14];
	xfer_t        pending [$];
	// reference words, low window of each region only
	ahb_data_t    model_inst [WINDOW];
	ahb_data_t    model_data [WINDOW];
	logic [31:0]  rng_state;
	int           n_checked;

	ahb_subsys_top #(
		.MEM_WORDS        (MEM_WORDS),
		.INST_WAIT_STATES (INST_WS),
		.DATA_WAIT_STATES (DATA_WS)
	) dut (
		.hclk       (hclk),
		.rst_n      (rst_n),
		.master_in  (master_in),
		.master_out (master_out)
	);

	initial hclk = 1'b0;
	always #10 hclk = ~hclk;

	// ==================================================
	// failure reporting and checks
	// ==================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_resp(input slv_send_type got, input logic exp_resp,
		input logic exp_ready, input string what);
		if (got.hresp !== exp_resp || got.hreadyout !== exp_ready) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s, hresp %b hreadyout %b, expected %b %b",
				$time, what, got.hresp, got.hreadyout, exp_resp, exp_ready));
		end
	endtask

	task automatic check_rdata(input ahb_data_t got, input ahb_data_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s, hrdata %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_waits(input int got, input int exp, input string what);
		if (got != exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s, %0d wait cycles, expected %0d",
				$time, what, got, exp));
		end
	endtask

	// ==================================================
	// address map and expected timing
	// ==================================================
	function automatic bit is_inst(input ahb_addr_t a);
		return (a & REGION_MASK) == INST_BASE;
	endfunction

	function automatic bit is_data(input ahb_addr_t a);
		return (a & REGION_MASK) == DATA_BASE;
	endfunction

	function automatic bit is_real(input xfer_t x);
		return x.htrans == NONSEQ || x.htrans == SEQ;
	endfunction

	// low cycles before the completing cycle
	function automatic int waits_for(input xfer_t x);
		if (!is_real(x)) return 0;
		if (is_inst(x.haddr)) return INST_WS;
		if (is_data(x.haddr)) return DATA_WS;
		// unmapped, one stalled ERROR cycle
		return 1;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// pattern built from every address bit
	function automatic ahb_data_t fill_word(input ahb_addr_t a);
		return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_96e1;
	endfunction

	// ==================================================
	// reference model and transfer queue
	// ==================================================
	task automatic note_write(input xfer_t x);
		if (x.hwrite && is_real(x)) begin
			if (is_inst(x.haddr)) begin
				model_inst[x.haddr[6:2]] = x.hwdata;
			end else if (is_data(x.haddr)) begin
				model_data[x.haddr[6:2]] = x.hwdata;
			end
		end
	endtask

	task automatic queue_xfer(input htrans_t tr, input logic wr, input ahb_addr_t a,
		input ahb_data_t d);
		xfer_t x;
		x.htrans    = tr;
		x.hwrite    = wr;
		x.haddr     = a;
		x.hwdata    = d;
		x.exp_resp  = is_real(x) && !is_inst(a) && !is_data(a);
		x.exp_rdata = '0;
		if (is_real(x) && !wr && !x.exp_resp) begin
			x.exp_rdata = is_inst(a) ? model_inst[a[6:2]] : model_data[a[6:2]];
		end
		note_write(x);
		pending.push_back(x);
	endtask

	function automatic xfer_t make_row(input htrans_t tr, input logic wr, input ahb_addr_t a,
		input ahb_data_t d, input logic resp, input ahb_data_t rd);
		xfer_t x;
		x.htrans    = tr;
		x.hwrite    = wr;
		x.haddr     = a;
		x.hwdata    = d;
		x.exp_resp  = resp;
		x.exp_rdata = rd;
		return x;
	endfunction

	// htrans, hwrite, haddr, hwdata, expected hresp, expected hrdata
	task automatic load_table();
		table_rows[0]  = make_row(NONSEQ, 1'b1, 32'h0000_0010, 32'h1111_2222, 1'b0, 32'h0);
		table_rows[1]  = make_row(NONSEQ, 1'b0, 32'h0000_0010, 32'h0, 1'b0, 32'h1111_2222);
		table_rows[2]  = make_row(NONSEQ, 1'b1, 32'h2000_0020, 32'hdead_beef, 1'b0, 32'h0);
		table_rows[3]  = make_row(NONSEQ, 1'b0, 32'h2000_0020, 32'h0, 1'b0, 32'hdead_beef);
		// unmapped space, then an idle to the same address
		table_rows[4]  = make_row(NONSEQ, 1'b0, 32'h4000_0000, 32'h0, 1'b1, 32'h0);
		table_rows[5]  = make_row(NONSEQ, 1'b1, 32'h4000_0004, 32'h0bad_f00d, 1'b1, 32'h0);
		table_rows[6]  = make_row(IDLE, 1'b0, 32'h4000_0000, 32'h0, 1'b0, 32'h0);
		// mixed regions back to back, data access right before inst
		table_rows[7]  = make_row(NONSEQ, 1'b1, 32'h2000_0040, 32'ha5a5_0001, 1'b0, 32'h0);
		table_rows[8]  = make_row(SEQ, 1'b1, 32'h0000_0044, 32'h5a5a_0002, 1'b0, 32'h0);
		table_rows[9]  = make_row(NONSEQ, 1'b0, 32'h2000_0040, 32'h0, 1'b0, 32'ha5a5_0001);
		table_rows[10] = make_row(NONSEQ, 1'b0, 32'h0000_0044, 32'h0, 1'b0, 32'h5a5a_0002);
		table_rows[11] = make_row(IDLE, 1'b1, 32'h2000_0040, 32'h0, 1'b0, 32'h0);
		table_rows[12] = make_row(NONSEQ, 1'b0, 32'h1000_0000, 32'h0, 1'b1, 32'h0);
		table_rows[13] = make_row(NONSEQ, 1'b0, 32'h2000_0020, 32'h0, 1'b0, 32'hdead_beef);
	endtask

	task automatic fill_windows();
		ahb_addr_t a;
		for (int i = 0; i < WINDOW; i++) begin
			a = INST_BASE | ahb_addr_t'(i << 2);
			queue_xfer(NONSEQ, 1'b1, a, fill_word(a));
			a = DATA_BASE | ahb_addr_t'(i << 2);
			queue_xfer(NONSEQ, 1'b1, a, fill_word(a));
		end
	endtask

	task automatic queue_random(input int n);
		logic [31:0] r;
		ahb_addr_t   a;
		htrans_t     tr;
		for (int i = 0; i < n; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			a = {25'd0, r[8:4], 2'b00};
			case (r[2:0])
				3'd0, 3'd1, 3'd2: a = INST_BASE | a;
				3'd3, 3'd4, 3'd5: a = DATA_BASE | a;
				default: a = 32'h4000_0000 | a;
			endcase
			tr = r[10] ? SEQ : NONSEQ;
			if (r[15:12] == 4'd0) begin
				tr = IDLE;
			end
			rng_state = xorshift32(rng_state);
			queue_xfer(tr, r[9], a, rng_state);
		end
	endtask

	// ==================================================
	// pipelined master
	// ==================================================
	task automatic drive_addr(input xfer_t x);
		master_in.haddr  <= x.haddr;
		master_in.htrans <= x.htrans;
		master_in.hwrite <= x.hwrite;
	endtask

	// address phase of one transfer overlaps the data phase of the one before
	task automatic run_pending();
		xfer_t        ap;
		xfer_t        dp;
		logic         ap_valid;
		logic         dp_valid;
		int           low_cnt;
		slv_send_type rsp;
		ap       = '0;
		dp       = '0;
		ap_valid = 1'b0;
		dp_valid = 1'b0;
		low_cnt  = 0;
		@(posedge hclk);
		if (pending.size() > 0) begin
			ap       = pending.pop_front();
			ap_valid = 1'b1;
			drive_addr(ap);
		end
		while (ap_valid || dp_valid) begin
			// outputs only move on the rising edge
			@(negedge hclk);
			rsp = master_out;
			if (!rsp.hreadyout) begin
				low_cnt++;
				if (low_cnt > MAX_WAIT) begin
					abort_run($sformatf("transfer %0d to %h hung, hreadyout low for %0d cycles",
						n_checked, dp.haddr, low_cnt));
				end
				if (dp_valid) begin
					check_resp(rsp, dp.exp_resp, 1'b0, $sformatf("wait cycle at %h", dp.haddr));
					if (dp.exp_resp) begin
						check_rdata(rsp.hrdata, '0, $sformatf("error cycle at %h", dp.haddr));
					end
				end else begin
					check_resp(rsp, 1'b0, 1'b1, "bus with no data phase");
				end
				@(posedge hclk);
			end else begin
				if (dp_valid) begin
					check_resp(rsp, dp.exp_resp, 1'b1, $sformatf("response at %h", dp.haddr));
					check_waits(low_cnt, waits_for(dp), $sformatf("data phase at %h", dp.haddr));
					if (is_real(dp) && (!dp.hwrite || dp.exp_resp)) begin
						check_rdata(rsp.hrdata, dp.exp_rdata, $sformatf("read at %h", dp.haddr));
					end
					n_checked++;
				end else begin
					check_resp(rsp, 1'b0, 1'b1, "idle bus");
				end
				// edge below accepts the driven address phase
				dp       = ap;
				dp_valid = ap_valid;
				low_cnt  = 0;
				@(posedge hclk);
				if (dp_valid) begin
					master_in.hwdata <= dp.hwdata;
				end
				if (pending.size() > 0) begin
					ap       = pending.pop_front();
					ap_valid = 1'b1;
					drive_addr(ap);
				end else begin
					ap_valid = 1'b0;
					master_in.htrans <= IDLE;
				end
			end
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		mas_send_type init_req;
		init_req        = '0;
		init_req.htrans = IDLE;
		init_req.hsize  = 3'b010;
		init_req.hprot  = 4'b0011;
		init_req.hready = 1'b1;
		master_in <= init_req;
		rst_n     <= 1'b0;
		rng_state = 32'habb0;
		n_checked = 0;
		repeat (16) @(posedge hclk);
		rst_n <= 1'b1;
		@(negedge hclk);
		check_resp(master_out, 1'b0, 1'b1, "master_out after reset");

		load_table();
		foreach (table_rows[i]) begin
			note_write(table_rows[i]);
			pending.push_back(table_rows[i]);
		end
		run_pending();

		// known contents before random reads
		fill_windows();
		run_pending();
		queue_random(N_RANDOM);
		run_pending();

		$display("checked %0d data phases", n_checked);
		$display("TESTS PASSED");
		$finish;
	end

endmodule : ahb_bus_tb
